// File: src/stack_cfg_pkg.sv
/* stack unit configuration: forth cell width, depth count types
   and the packed status word reported by the stack engine */
package stack_cfg_pkg;

    localparam int WORD_W       = 32;   // one forth cell
    localparam int DS_DEPTH_MAX = 256;  // largest data stack ram supported
    localparam int RS_DEPTH_MAX = 256;  // largest return stack ram supported

    // one forth cell, used for tos, literals and ram words
    typedef logic [WORD_W-1:0] word_t;

    // data count spans 0 .. ram depth + 1, the tos register included
    typedef logic [$clog2(DS_DEPTH_MAX + 2)-1:0] ds_depth_t;

    // return count spans 0 .. ram depth, no register in front
    typedef logic [$clog2(RS_DEPTH_MAX + 1)-1:0] rs_depth_t;

    // observable stack state, updated together with tos
    typedef struct packed {
        ds_depth_t ds_depth;  // items on data stack incl tos
        rs_depth_t rs_depth;  // items on return stack
        logic      error;     // last command was rejected
    } stack_status_t;

endpackage

// File: src/forth_op_pkg.sv
/* forth primitive opcodes, command word and the stack effect
   tables used by the engine to check and apply each primitive */
package forth_op_pkg;

    typedef enum logic [3:0] {
        OP_NOP     = 4'h0,
        OP_LIT     = 4'h1,  // push literal operand
        OP_DUP     = 4'h2,
        OP_DROP    = 4'h3,
        OP_SWAP    = 4'h4,
        OP_OVER    = 4'h5,
        OP_ADD     = 4'h6,
        OP_SUB     = 4'h7,  // nos - tos
        OP_AND     = 4'h8,
        OP_XOR     = 4'h9,
        OP_TO_R    = 4'ha,  // >r
        OP_R_FROM  = 4'hb,  // r>
        OP_R_FETCH = 4'hc   // r@
    } op_e;

    typedef struct packed {
        op_e                  op;
        stack_cfg_pkg::word_t lit;  // only read by OP_LIT
    } cmd_t;

    // data items the primitive consumes
    function automatic int ds_need(op_e op);
        case (op)
            OP_DUP, OP_DROP, OP_TO_R:                          return 1;
            OP_SWAP, OP_OVER, OP_ADD, OP_SUB, OP_AND, OP_XOR:  return 2;
            default:                                           return 0;
        endcase
    endfunction

    // net change of the data depth
    function automatic int ds_grow(op_e op);
        case (op)
            OP_LIT, OP_DUP, OP_OVER, OP_R_FROM, OP_R_FETCH:   return 1;
            OP_DROP, OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_TO_R: return -1;
            default:                                          return 0;
        endcase
    endfunction

    function automatic int rs_need(op_e op);
        case (op)
            OP_R_FROM, OP_R_FETCH: return 1;
            default:               return 0;
        endcase
    endfunction

    function automatic int rs_grow(op_e op);
        case (op)
            OP_TO_R:   return 1;
            OP_R_FROM: return -1;
            default:   return 0;
        endcase
    endfunction

endpackage

// File: src/spram.sv
/* behavioral single-port ram, synchronous write and registered read,
   write-first on the shared port; stands in for the block ram primitive */
module spram #(
    parameter int DEPTH = 64,                    // words
    parameter int DSZ   = stack_cfg_pkg::WORD_W  // word width
) (
    input  logic                        clk,
    input  logic [$clog2(DEPTH)-1:0]    addr,   // shared rd/wr address
    input  logic                        we,
    input  stack_cfg_pkg::word_t        wdata,
    output stack_cfg_pkg::word_t        rdata   // one cycle after addr
);
    import stack_cfg_pkg::*;

    logic [DSZ-1:0] mem [DEPTH];  // storage, no reset

    // port width is fixed by the package cell type
    if (DSZ != $bits(word_t)) begin : g_dsz_check
        $error("spram DSZ must equal the forth cell width");
    end

    if (DEPTH < 2) begin : g_depth_check
        $error("spram DEPTH must be at least 2");
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            rdata     <= wdata;      // write-first, new data on the port
        end else begin
            rdata     <= mem[addr];  // plain registered read
        end
    end

endmodule

// File: src/lifo_stack.sv
/* ram backed lifo: index register plus single-port ram, presents
   the element just below the index on nos one cycle after it settles */
module lifo_stack #(
    parameter int DEPTH = 64,
    parameter int DSZ   = stack_cfg_pkg::WORD_W
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,   // write vi at idx, idx+1
    input  logic                 pop,    // idx-1
    input  logic                 rep,    // replace top in place, idx kept
    input  stack_cfg_pkg::word_t vi,
    output stack_cfg_pkg::word_t nos,    // ram[idx-1]
    output logic                 full,
    output logic                 empty
);
    localparam int IW = $clog2(DEPTH + 1);  // index counts 0 .. DEPTH
    localparam int AW = $clog2(DEPTH);      // ram address

    logic [IW-1:0] idx;      // items held
    logic [IW-1:0] idx_m1;   // idx - 1
    logic [AW-1:0] addr;
    logic          we;

    assign idx_m1 = idx - 1'b1;
    // push writes the free slot, everything else looks at the top
    assign addr   = push ? idx[AW-1:0] : idx_m1[AW-1:0];
    assign we     = push | rep;  // rep overwrites ram[idx-1]

    spram #(
        .DEPTH (DEPTH),
        .DSZ   (DSZ)
    ) ram_i (
        .clk   (clk),
        .addr  (addr),
        .we    (we),
        .wdata (vi),
        .rdata (nos)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            idx <= '0;
        end else if (push) begin
            idx <= idx + 1'b1;
        end else if (pop) begin
            idx <= idx_m1;
        end
    end

    assign full  = (idx == IW'(DEPTH));
    assign empty = (idx == '0);

    // engine must keep the ops exclusive and within bounds
    a_one_op: assert property (@(posedge clk) disable iff (rst)
        $onehot0({push, pop, rep}))
        else $error("lifo got more than one op in a cycle");

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> !full)
        else $error("lifo push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        (pop || rep) |-> !empty)
        else $error("lifo pop or replace while empty");

endmodule

// File: src/stack_engine.sv
/* stack engine with the idle/exec/settle sequencer, tos register, depth checks,
   alu primitives and the push/pop/replace controls of both lifos */
module stack_engine #(
    parameter int DS_DEPTH = 16,                    // data ram words
    parameter int RS_DEPTH = 16,                    // return ram words
    parameter int DSZ      = stack_cfg_pkg::WORD_W
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cmd_valid,  // one cycle strobe
    input  forth_op_pkg::cmd_t            cmd,
    input  stack_cfg_pkg::word_t          ds_nos,     // data ram top
    input  stack_cfg_pkg::word_t          rs_top,     // return ram top
    input  logic                          ds_full,
    input  logic                          ds_empty,
    input  logic                          rs_full,
    input  logic                          rs_empty,
    output logic                          ds_push,
    output logic                          ds_pop,
    output logic                          ds_rep,     // swap writes in place
    output logic                          rs_push,
    output logic                          rs_pop,
    output stack_cfg_pkg::word_t          ds_vi,
    output stack_cfg_pkg::word_t          rs_vi,
    output stack_cfg_pkg::word_t          tos,
    output stack_cfg_pkg::stack_status_t  status,
    output logic                          busy,
    output logic                          done,       // 2 cycles after strobe
    output logic                          err         // with done
);
    import stack_cfg_pkg::*;
    import forth_op_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        SETTLE
    } state_e;

    state_e    state;
    cmd_t      cmd_q;      // latched command
    ds_depth_t ds_cnt;     // tos + data ram items
    rs_depth_t rs_cnt;
    logic      err_q;      // sticky until next command
    logic      ds_under;
    logic      rs_under;
    logic      ds_over;
    logic      rs_over;
    logic      fail;
    logic      exec_ok;    // exec cycle with all checks passed
    word_t     tos_nxt;

    if (DSZ != $bits(word_t)) begin : g_dsz_check
        $error("engine DSZ must equal the forth cell width");
    end

    if (DS_DEPTH > DS_DEPTH_MAX || RS_DEPTH > RS_DEPTH_MAX) begin : g_depth_check
        $error("stack depth exceeds the status count width");
    end

    // count rules on the latched command
    assign ds_under = int'(ds_cnt) < ds_need(cmd_q.op);
    assign rs_under = int'(rs_cnt) < rs_need(cmd_q.op);
    assign ds_over  = (ds_grow(cmd_q.op) > 0) && (ds_cnt != '0) && ds_full;
    assign rs_over  = (rs_grow(cmd_q.op) > 0) && rs_full;
    assign fail     = ds_under | rs_under | ds_over | rs_over;
    assign exec_ok  = (state == EXEC) && !fail;

    // lifo controls follow straight from the effect tables
    assign ds_push = exec_ok && (ds_grow(cmd_q.op) > 0) && (ds_cnt != '0);  // tos held
    assign ds_pop  = exec_ok && (ds_grow(cmd_q.op) < 0) && !ds_empty;
    assign ds_rep  = exec_ok && (cmd_q.op == OP_SWAP);
    assign rs_push = exec_ok && (rs_grow(cmd_q.op) > 0);
    assign rs_pop  = exec_ok && (rs_grow(cmd_q.op) < 0);
    assign ds_vi   = tos;  // old tos sinks into data ram
    assign rs_vi   = tos;  // >r moves tos

    always_comb begin
        tos_nxt = tos;
        case (cmd_q.op)
            OP_LIT:                tos_nxt = cmd_q.lit;
            OP_DROP, OP_TO_R:      tos_nxt = ds_empty ? '0 : ds_nos;  // empty shows 0
            OP_SWAP, OP_OVER:      tos_nxt = ds_nos;
            OP_ADD:                tos_nxt = ds_nos + tos;
            OP_SUB:                tos_nxt = ds_nos - tos;
            OP_AND:                tos_nxt = ds_nos & tos;
            OP_XOR:                tos_nxt = ds_nos ^ tos;
            OP_R_FROM, OP_R_FETCH: tos_nxt = rs_top;
            default:               tos_nxt = tos;  // nop, dup
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            ds_cnt <= '0;
            rs_cnt <= '0;
            tos    <= '0;
            err_q  <= 1'b0;
            done   <= 1'b0;
            err    <= 1'b0;
        end else begin
            done <= 1'b0;
            err  <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    state <= SETTLE;
                    done  <= 1'b1;  // lands in settle
                    err   <= fail;
                    err_q <= fail;
                    if (!fail) begin  // rejected command leaves state alone
                        tos    <= tos_nxt;
                        ds_cnt <= ds_depth_t'(int'(ds_cnt) + ds_grow(cmd_q.op));
                        rs_cnt <= rs_depth_t'(int'(rs_cnt) + rs_grow(cmd_q.op));
                    end
                end
                SETTLE: state <= IDLE;  // ram read of new top
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_valid) begin
            cmd_q <= cmd;  // strobes while busy are dropped
        end
    end

    assign busy            = (state != IDLE);
    assign status.ds_depth = ds_cnt;
    assign status.rs_depth = rs_cnt;
    assign status.error    = err_q;

    // done two cycles after an accepted strobe and one cycle wide
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        (cmd_valid && !busy) |=> !done ##1 done ##1 !done)
        else $error("done not a single pulse two cycles after the strobe");

    // lifo ops only for a command that passed its checks
    a_ops_in_exec: assert property (@(posedge clk) disable iff (rst)
        (ds_push || ds_pop || ds_rep || rs_push || rs_pop) |=> (done && !err))
        else $error("lifo op issued outside an accepted exec");

    // engine counts must track the lifo index registers
    a_cnt_track: assert property (@(posedge clk) disable iff (rst)
        (rs_empty == (rs_cnt == '0)) && (ds_empty == (ds_cnt <= ds_depth_t'(1))))
        else $error("engine depth disagrees with lifo state");

endmodule

// File: src/forth_stack_unit.sv
/* forth stack unit top: stack engine with the data and return lifos */
module forth_stack_unit #(
    parameter int DS_DEPTH = 16,
    parameter int RS_DEPTH = 16,
    parameter int DSZ      = stack_cfg_pkg::WORD_W
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cmd_valid,
    input  forth_op_pkg::cmd_t            cmd,
    output stack_cfg_pkg::word_t          tos,
    output stack_cfg_pkg::stack_status_t  status,
    output logic                          busy,
    output logic                          done,
    output logic                          err
);
    import stack_cfg_pkg::*;

    word_t ds_vi;    // engine to data lifo
    word_t rs_vi;
    word_t ds_nos;   // data lifo top
    word_t rs_nos;   // return lifo top
    logic  ds_push;
    logic  ds_pop;
    logic  ds_rep;
    logic  rs_push;
    logic  rs_pop;
    logic  ds_full;
    logic  ds_empty;
    logic  rs_full;
    logic  rs_empty;

    stack_engine #(
        .DS_DEPTH (DS_DEPTH),
        .RS_DEPTH (RS_DEPTH),
        .DSZ      (DSZ)
    ) eng_i (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .ds_nos    (ds_nos),
        .rs_top    (rs_nos),
        .ds_full   (ds_full),
        .ds_empty  (ds_empty),
        .rs_full   (rs_full),
        .rs_empty  (rs_empty),
        .ds_push   (ds_push),
        .ds_pop    (ds_pop),
        .ds_rep    (ds_rep),
        .rs_push   (rs_push),
        .rs_pop    (rs_pop),
        .ds_vi     (ds_vi),
        .rs_vi     (rs_vi),
        .tos       (tos),
        .status    (status),
        .busy      (busy),
        .done      (done),
        .err       (err)
    );

    lifo_stack #(
        .DEPTH (DS_DEPTH),
        .DSZ   (DSZ)
    ) ds_i (
        .clk   (clk),
        .rst   (rst),
        .push  (ds_push),
        .pop   (ds_pop),
        .rep   (ds_rep),
        .vi    (ds_vi),
        .nos   (ds_nos),
        .full  (ds_full),
        .empty (ds_empty)
    );

    lifo_stack #(
        .DEPTH (RS_DEPTH),
        .DSZ   (DSZ)
    ) rs_i (
        .clk   (clk),
        .rst   (rst),
        .push  (rs_push),
        .pop   (rs_pop),
        .rep   (1'b0),  // no in-place op on return stack
        .vi    (rs_vi),
        .nos   (rs_nos),
        .full  (rs_full),
        .empty (rs_empty)
    );

endmodule

// File: verification/forth_stack_unit_tb.sv
/* directed tests for the forth stack unit with a queue based reference model
   of both stacks, per command done check, watchdog and summary line */
module forth_stack_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import stack_cfg_pkg::*;
    import forth_op_pkg::*;

    localparam int DS_DEPTH    = 8;             // data ram words
    localparam int RS_DEPTH    = 6;             // return ram words
    localparam int DS_LIMIT    = DS_DEPTH + 1;  // ram plus tos register
    localparam int ALU_ROUNDS  = 6;
    localparam int DONE_WAIT   = 8;             // cycles before giving up on done
    localparam int N_CMDS      = 2 + (2 * DS_LIMIT + 2) + ALU_ROUNDS * 16 + 24
                               + (3 * RS_DEPTH + 24) + 12;
    localparam int WATCHDOG_NS = (N_CMDS * 4 + 100) * 100;  // 4 cycles per command

    logic          clk = 1'b0;
    logic          rst;
    logic          cmd_valid;
    cmd_t          cmd;
    word_t         tos;
    stack_status_t status;
    logic          busy;
    logic          done;
    logic          err;

    word_t ds_q[$];      // model data stack, last entry is tos
    word_t rs_q[$];      // model return stack
    int    n_checks   = 0;
    int    n_errors   = 0;
    int    n_timeouts = 0;

    always #50 clk = ~clk;  // 100 ns period

    forth_stack_unit #(
        .DS_DEPTH (DS_DEPTH),
        .RS_DEPTH (RS_DEPTH),
        .DSZ      (WORD_W)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tos       (tos),
        .status    (status),
        .busy      (busy),
        .done      (done),
        .err       (err)
    );

    task automatic report_mismatch(input string msg);
        n_errors++;
        $display("ERROR at %0d ns: %s", $time, msg);
    endtask

    // one primitive on the model, rejected when a count rule fails
    task automatic model_apply(input op_e op, input word_t lit, output bit bad);
        int    dn = 0;   // data items needed
        int    rn = 0;   // return items needed
        int    dg = 0;   // data growth
        int    rg = 0;   // return growth
        word_t a;
        word_t b;
        case (op)
            OP_LIT: dg = 1;
            OP_DUP: begin
                dn = 1;
                dg = 1;
            end
            OP_DROP: begin
                dn = 1;
                dg = -1;
            end
            OP_SWAP: dn = 2;
            OP_OVER: begin
                dn = 2;
                dg = 1;
            end
            OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                dn = 2;
                dg = -1;
            end
            OP_TO_R: begin
                dn = 1;
                dg = -1;
                rg = 1;
            end
            OP_R_FROM: begin
                rn = 1;
                dg = 1;
                rg = -1;
            end
            OP_R_FETCH: begin
                rn = 1;
                dg = 1;
            end
            default: dg = 0;  // nop
        endcase
        bad = (ds_q.size() < dn) || (rs_q.size() < rn)
            || (ds_q.size() + dg > DS_LIMIT) || (rs_q.size() + rg > RS_DEPTH);
        if (!bad) begin
            case (op)
                OP_LIT:  ds_q.push_back(lit);
                OP_DUP:  ds_q.push_back(ds_q[$]);
                OP_DROP: a = ds_q.pop_back();
                OP_SWAP: begin
                    a = ds_q.pop_back();
                    b = ds_q.pop_back();
                    ds_q.push_back(a);
                    ds_q.push_back(b);
                end
                OP_OVER: ds_q.push_back(ds_q[$-1]);
                OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                    a = ds_q.pop_back();  // tos
                    b = ds_q.pop_back();  // nos
                    if (op == OP_ADD) ds_q.push_back(b + a);
                    else if (op == OP_SUB) ds_q.push_back(b - a);  // nos - tos
                    else if (op == OP_AND) ds_q.push_back(b & a);
                    else ds_q.push_back(b ^ a);
                end
                OP_TO_R:    rs_q.push_back(ds_q.pop_back());
                OP_R_FROM:  ds_q.push_back(rs_q.pop_back());
                OP_R_FETCH: ds_q.push_back(rs_q[$]);
                default:    a = '0;
            endcase
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < DONE_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            n_timeouts++;
            $display("DUT stayed busy for %0d cycles and took no new command", DONE_WAIT);
        end
    endtask

    // counts falling edges until done shows up
    task automatic wait_done(output int cycles, output bit seen);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_WAIT) begin
            @(negedge clk);
            cycles++;
            seen = done;
        end
    endtask

    task automatic check_outputs(input op_e op, input bit exp_err, input int lat,
                                 input int exp_lat);
        n_checks++;
        if (lat != exp_lat)
            report_mismatch($sformatf("%s done after %0d cycles, expected %0d",
                                      op.name(), lat, exp_lat));
        if (busy !== 1'b1)
            report_mismatch($sformatf("%s busy low in the done cycle", op.name()));
        if (err !== exp_err)
            report_mismatch($sformatf("%s err %b, expected %b", op.name(), err, exp_err));
        if (status.error !== exp_err)
            report_mismatch($sformatf("%s status error %b, expected %b",
                                      op.name(), status.error, exp_err));
        if (int'(status.ds_depth) != ds_q.size())
            report_mismatch($sformatf("%s data depth %0d, expected %0d",
                                      op.name(), status.ds_depth, ds_q.size()));
        if (int'(status.rs_depth) != rs_q.size())
            report_mismatch($sformatf("%s return depth %0d, expected %0d",
                                      op.name(), status.rs_depth, rs_q.size()));
        if (ds_q.size() > 0) begin
            if (tos !== ds_q[$])
                report_mismatch($sformatf("%s tos %h, expected %h", op.name(), tos, ds_q[$]));
        end
    endtask

    task automatic issue(input op_e op, input word_t lit);
        cmd_t c;
        bit   exp_err;
        int   cycles;
        bit   seen;
        c.op  = op;
        c.lit = lit;
        wait_idle();
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk);
        cmd_valid <= 1'b0;    // strobe accepted on this edge
        model_apply(op, lit, exp_err);
        wait_done(cycles, seen);
        if (!seen) begin
            n_timeouts++;
            $display("no done pulse for %s within %0d cycles", op.name(), DONE_WAIT);
        end else begin
            check_outputs(op, exp_err, cycles, 2);
        end
    endtask

    // second strobe lands in the exec cycle of the first
    task automatic issue_during_busy(input op_e op, input word_t lit,
                                     input op_e op2, input word_t lit2);
        cmd_t c;
        cmd_t c2;
        bit   exp_err;
        int   cycles;
        bit   seen;
        c.op   = op;
        c.lit  = lit;
        c2.op  = op2;
        c2.lit = lit2;
        wait_idle();
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk);
        cmd       <= c2;      // valid stays high, dut is busy now
        @(posedge clk);
        cmd_valid <= 1'b0;
        model_apply(op, lit, exp_err);  // only the first command counts
        wait_done(cycles, seen);
        if (!seen) begin
            n_timeouts++;
            $display("no done pulse for %s within %0d cycles", op.name(), DONE_WAIT);
        end else begin
            check_outputs(op, exp_err, cycles, 1);
        end
        wait_done(cycles, seen);
        if (seen)
            report_mismatch($sformatf("extra done after %s, busy strobe was taken",
                                      op2.name()));
    endtask

    task automatic clear_data();
        while (ds_q.size() > 0) begin
            issue(OP_DROP, '0);
        end
    endtask

    task automatic check_reset_state();
        n_checks++;
        if (int'(status.ds_depth) != 0 || int'(status.rs_depth) != 0 || err !== 1'b0
            || busy !== 1'b0 || done !== 1'b0)
            report_mismatch("after reset the stacks are not empty or the dut is not idle");
        issue(OP_DROP, '0);  // underflow on empty data stack
        issue(OP_NOP, '0);
    endtask

    task automatic fill_and_drain_data();
        for (int i = 0; i < DS_LIMIT; i++) begin
            issue(OP_LIT, word_t'(32'h100 + i));
        end
        issue(OP_LIT, 32'hdead_beef);  // one past ram plus tos
        for (int i = DS_LIMIT - 1; i >= 0; i--) begin
            n_checks++;
            if (tos !== word_t'(32'h100 + i))
                report_mismatch($sformatf("drain tos %h, expected %h", tos, 32'h100 + i));
            issue(OP_DROP, '0);
        end
        issue(OP_DROP, '0);
    endtask

    task automatic run_alu_ops();
        op_e ops[4];
        ops[0] = OP_ADD;
        ops[1] = OP_SUB;
        ops[2] = OP_AND;
        ops[3] = OP_XOR;
        for (int r = 0; r < ALU_ROUNDS; r++) begin
            for (int k = 0; k < 4; k++) begin
                issue(OP_LIT, $urandom());
                issue(OP_LIT, $urandom());
                issue(ops[k], '0);   // depth 2 -> 1
                issue(OP_DROP, '0);
            end
        end
    endtask

    task automatic shuffle_data();
        issue(OP_LIT, 32'h11);
        issue(OP_SWAP, '0);  // only one item
        issue(OP_OVER, '0);
        issue(OP_LIT, 32'h22);
        issue(OP_SWAP, '0);
        issue(OP_OVER, '0);
        issue(OP_DUP, '0);
        issue(OP_LIT, 32'h33);
        issue(OP_SWAP, '0);
        issue(OP_OVER, '0);
        issue(OP_SWAP, '0);
        issue(OP_DROP, '0);
        issue(OP_OVER, '0);
        clear_data();
        issue(OP_DUP, '0);   // empty again
    endtask

    task automatic move_through_return();
        issue(OP_TO_R, '0);     // no data
        issue(OP_R_FETCH, '0);  // no return item
        for (int i = 0; i <= RS_DEPTH; i++) begin
            issue(OP_LIT, word_t'(32'h7000 + i));
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            issue(OP_TO_R, '0);
        end
        issue(OP_TO_R, '0);     // return stack full
        issue(OP_R_FETCH, '0);
        for (int i = 0; i < RS_DEPTH; i++) begin
            issue(OP_R_FROM, '0);
        end
        issue(OP_R_FROM, '0);   // return stack empty
        issue(OP_LIT, 32'h7777);
        issue(OP_TO_R, '0);
        issue(OP_LIT, 32'h7778);
        issue(OP_R_FETCH, '0);  // data stack full
        issue(OP_R_FROM, '0);
        clear_data();
        issue(OP_R_FROM, '0);
        clear_data();
    endtask

    task automatic strobe_while_busy();
        issue(OP_LIT, 32'h55);
        issue_during_busy(OP_LIT, 32'h1234, OP_DROP, '0);
        clear_data();
    endtask

    initial begin
        void'($urandom(11225));  // fixed seed for the run
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_reset_state();
        fill_and_drain_data();
        run_alu_ops();
        shuffle_data();
        move_through_return();
        strobe_while_busy();
        $display("checks %0d, value errors %0d, missing done %0d",
                 n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: forth_stack_unit.f
src/stack_cfg_pkg.sv
src/forth_op_pkg.sv
src/spram.sv
src/lifo_stack.sv
src/stack_engine.sv
src/forth_stack_unit.sv
verification/forth_stack_unit_tb.sv

// File: Makefile
# Verilator build and run of the forth stack unit testbench

VERILATOR ?= verilator
TOP       ?= forth_stack_unit_tb
FILELIST  ?= forth_stack_unit.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing -j 0
SIM_BIN    = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
